// ==== src/eth_mac_pkg.sv ====
// --------------------
// eth_mac_pkg
// widths, stream beat structs and framing state shared by the
// dual-channel 100G MAC adapter
// --------------------

package eth_mac_pkg;

    localparam int DATA_WIDTH    = 64;
    localparam int KEEP_WIDTH    = DATA_WIDTH / 8;
    localparam int EMPTY_WIDTH   = $clog2(KEEP_WIDTH);
    localparam int PTP_TS_WIDTH  = 96;
    localparam int PTP_TAG_WIDTH = 8;
    localparam int MAC_ERR_WIDTH = 6;
    localparam int TX_USER_WIDTH = PTP_TAG_WIDTH + 1;  // tag above the error bit
    localparam int RX_USER_WIDTH = PTP_TS_WIDTH + 1;   // timestamp above the error bit

    typedef struct packed {
        logic                     valid;
        logic [DATA_WIDTH-1:0]    data;
        logic [KEEP_WIDTH-1:0]    keep;
        logic                     last;
        logic [TX_USER_WIDTH-1:0] user;
    } axis_tx_t;

    typedef struct packed {
        logic                   valid;
        logic [DATA_WIDTH-1:0]  data;
        logic                   startofpacket;
        logic                   endofpacket;
        logic [EMPTY_WIDTH-1:0] empty;
        logic                   error;
    } avst_tx_t;

    typedef struct packed {
        logic                     valid;
        logic [DATA_WIDTH-1:0]    data;
        logic                     startofpacket;
        logic                     endofpacket;
        logic [EMPTY_WIDTH-1:0]   empty;
        logic [MAC_ERR_WIDTH-1:0] error;
    } avst_rx_t;

    typedef struct packed {
        logic                     valid;
        logic [DATA_WIDTH-1:0]    data;
        logic [KEEP_WIDTH-1:0]    keep;
        logic                     last;
        logic [RX_USER_WIDTH-1:0] user;
    } axis_rx_t;

    typedef struct packed {
        logic                     valid;
        logic [PTP_TS_WIDTH-1:0]  ts;
        logic [PTP_TAG_WIDTH-1:0] tag;
    } ptp_ts_ret_t;

    typedef enum logic {
        FRAME_IDLE,  // next accepted beat opens a frame
        FRAME_BODY
    } frame_state_e;

    // Avalon carries the first byte in the top lane, AXI in the bottom lane
    function automatic logic [DATA_WIDTH-1:0] byte_swap(input logic [DATA_WIDTH-1:0] d);
        logic [DATA_WIDTH-1:0] r;
        for (int i = 0; i < KEEP_WIDTH; i++) begin
            r[8*i +: 8] = d[8*(KEEP_WIDTH-1-i) +: 8];
        end
        return r;
    endfunction

endpackage

// ==== src/mac_reset_sync.sv ====
// --------------------
// mac_reset_sync
// per-channel MAC reset, asserted asynchronously from system reset
// and MAC readiness, released through a flop chain
// --------------------

`timescale 1ns/1ps

module mac_reset_sync #(
    parameter int SYNC_STAGES = 4
) (
    input  logic i_mac_clk,
    input  logic i_arst_n,
    input  logic i_tx_lanes_stable,
    input  logic i_ehip_ready,
    output logic o_mac_rst
);

    logic                   rst_cond_n;
    logic [SYNC_STAGES-1:0] sync_q;

    // any missing condition holds the channel in reset
    assign rst_cond_n = i_arst_n & i_tx_lanes_stable & i_ehip_ready;

    always_ff @(posedge i_mac_clk or negedge rst_cond_n) begin
        if (!rst_cond_n) begin
            sync_q <= '1;
        end else begin
            sync_q <= sync_q << 1;  // release walks one stage per edge
        end
    end

    assign o_mac_rst = sync_q[SYNC_STAGES-1];

endmodule

// ==== src/axis_to_avst_tx.sv ====
// --------------------
// axis_to_avst_tx
// user AXI-Stream TX beats to the MAC Avalon-ST input, with
// start-of-packet generation and PTP tag extraction
// --------------------

`timescale 1ns/1ps

module axis_to_avst_tx
    import eth_mac_pkg::*;
#(
    parameter bit BYTE_REVERSE = 1'b1
) (
    input  logic                     i_mac_clk,
    input  logic                     i_mac_rst,

    input  axis_tx_t                 i_axis,
    output logic                     o_axis_ready,

    input  logic                     i_avst_ready,
    output avst_tx_t                 o_avst,
    output logic [PTP_TAG_WIDTH-1:0] o_ptp_tag
);

    frame_state_e          state_q;
    logic                  beat_accept;
    logic [DATA_WIDTH-1:0] data_out;

    // the MAC ready goes straight back to the user
    assign o_axis_ready = i_avst_ready;
    assign beat_accept  = i_axis.valid & i_avst_ready;

    always_ff @(posedge i_mac_clk or posedge i_mac_rst) begin
        if (i_mac_rst) begin
            state_q <= FRAME_IDLE;
        end else if (beat_accept) begin
            state_q <= i_axis.last ? FRAME_IDLE : FRAME_BODY;
        end
    end

    assign data_out = BYTE_REVERSE ? byte_swap(i_axis.data) : i_axis.data;

    always_comb begin
        o_avst.valid         = i_axis.valid;
        o_avst.data          = data_out;
        o_avst.startofpacket = (state_q == FRAME_IDLE);
        o_avst.endofpacket   = i_axis.last;
        // keep is contiguous from bit 0, so the cleared bits give the empty count
        o_avst.empty         = EMPTY_WIDTH'(KEEP_WIDTH - $countones(i_axis.keep));
        o_avst.error         = i_axis.user[0];
    end

    assign o_ptp_tag = i_axis.user[TX_USER_WIDTH-1:1];  // fingerprint for the egress timestamp

endmodule

// ==== src/avst_to_axis_rx.sv ====
// --------------------
// avst_to_axis_rx
// MAC Avalon-ST RX beats to AXI-Stream, keep rebuilt from empty
// --------------------

`timescale 1ns/1ps

module avst_to_axis_rx
    import eth_mac_pkg::*;
#(
    parameter bit BYTE_REVERSE = 1'b1
) (
    input  avst_rx_t i_avst,
    output axis_rx_t o_axis
);

    logic [KEEP_WIDTH-1:0] keep_out;
    logic [DATA_WIDTH-1:0] data_out;
    logic                  err_any;

    // only the closing beat can be partial
    assign keep_out = i_avst.endofpacket ? ({KEEP_WIDTH{1'b1}} >> i_avst.empty) : '1;
    assign data_out = BYTE_REVERSE ? byte_swap(i_avst.data) : i_avst.data;
    assign err_any  = |i_avst.error;  // any MAC error class marks the frame bad

    always_comb begin
        o_axis.valid = i_avst.valid;
        o_axis.data  = data_out;
        o_axis.keep  = keep_out;
        o_axis.last  = i_avst.endofpacket;
        o_axis.user  = {{PTP_TS_WIDTH{1'b0}}, err_any};  // timestamp is filled in downstream
    end

endmodule

// ==== src/rx_ts_insert.sv ====
// --------------------
// rx_ts_insert
// registers the RX beat and places the frame's ingress timestamp
// in the upper tuser bits of every beat
// --------------------

`timescale 1ns/1ps

module rx_ts_insert
    import eth_mac_pkg::*;
(
    input  logic                    i_mac_clk,
    input  logic                    i_mac_rst,
    input  logic [PTP_TS_WIDTH-1:0] i_ptp_rx_its,
    input  logic                    i_sop,
    input  axis_rx_t                i_axis,
    output axis_rx_t                o_axis
);

    logic                    sop_beat;
    logic [PTP_TS_WIDTH-1:0] ts_hold_q;
    logic [PTP_TS_WIDTH-1:0] ts_sel;

    logic                    valid_q;
    logic [DATA_WIDTH-1:0]   data_q;
    logic [KEEP_WIDTH-1:0]   keep_q;
    logic                    last_q;
    logic                    err_q;
    logic [PTP_TS_WIDTH-1:0] ts_q;

    assign sop_beat = i_axis.valid & i_sop;

    // the live value is only trusted on the first beat of the frame
    assign ts_sel = sop_beat ? i_ptp_rx_its : ts_hold_q;

    always_ff @(posedge i_mac_clk) begin
        if (sop_beat) begin
            ts_hold_q <= i_ptp_rx_its;
        end
    end

    always_ff @(posedge i_mac_clk or posedge i_mac_rst) begin
        if (i_mac_rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_axis.valid;  // no back-pressure on RX
        end
    end

    always_ff @(posedge i_mac_clk) begin
        data_q <= i_axis.data;
        keep_q <= i_axis.keep;
        last_q <= i_axis.last;
        err_q  <= i_axis.user[0];
        ts_q   <= ts_sel;
    end

    always_comb begin
        o_axis.valid = valid_q;
        o_axis.data  = data_q;
        o_axis.keep  = keep_q;
        o_axis.last  = last_q;
        o_axis.user  = {ts_q, err_q};
    end

endmodule

// ==== src/eth_mac_dual_adapter.sv ====
// --------------------
// eth_mac_dual_adapter
// dual-channel adapter between user AXI-Stream and the Avalon-ST
// side of a hard 100G MAC, with reset and PTP timestamp handling
// --------------------

`timescale 1ns/1ps

module eth_mac_dual_adapter
    import eth_mac_pkg::*;
#(
    parameter int N_CH         = 2,
    parameter int SYNC_STAGES  = 4,
    parameter bit BYTE_REVERSE = 1'b1
) (
    input  logic                                i_mac_clk,
    input  logic                                i_arst_n,

    // user side
    input  axis_tx_t    [N_CH-1:0]              i_tx_axis,
    output logic        [N_CH-1:0]              o_tx_axis_ready,
    output axis_rx_t    [N_CH-1:0]              o_rx_axis,
    output ptp_ts_ret_t [N_CH-1:0]              o_tx_ptp_ts,
    output logic        [N_CH-1:0]              o_rx_status,
    output logic        [N_CH-1:0]              o_mac_rst,

    // MAC side
    output avst_tx_t    [N_CH-1:0]              o_mac_tx,
    input  logic        [N_CH-1:0]              i_mac_tx_ready,
    output logic        [N_CH-1:0][PTP_TAG_WIDTH-1:0] o_mac_ptp_fp,
    input  avst_rx_t    [N_CH-1:0]              i_mac_rx,
    input  logic        [N_CH-1:0][PTP_TS_WIDTH-1:0]  i_mac_ptp_rx_its,
    input  ptp_ts_ret_t [N_CH-1:0]              i_mac_ptp_ets,
    input  logic        [N_CH-1:0]              i_mac_tx_lanes_stable,
    input  logic        [N_CH-1:0]              i_mac_ehip_ready,
    input  logic        [N_CH-1:0]              i_mac_rx_pcs_ready
);

    // egress timestamps and PCS status go to the user untouched
    assign o_tx_ptp_ts = i_mac_ptp_ets;
    assign o_rx_status = i_mac_rx_pcs_ready;

    for (genvar n = 0; n < N_CH; n++) begin : g_ch

        axis_rx_t rx_axis_int;

        mac_reset_sync #(
            .SYNC_STAGES       (SYNC_STAGES)
        ) u_reset_sync (
            .i_mac_clk         (i_mac_clk),
            .i_arst_n          (i_arst_n),
            .i_tx_lanes_stable (i_mac_tx_lanes_stable[n]),
            .i_ehip_ready      (i_mac_ehip_ready[n]),
            .o_mac_rst         (o_mac_rst[n])
        );

        axis_to_avst_tx #(
            .BYTE_REVERSE      (BYTE_REVERSE)
        ) u_tx (
            .i_mac_clk         (i_mac_clk),
            .i_mac_rst         (o_mac_rst[n]),
            .i_axis            (i_tx_axis[n]),
            .o_axis_ready      (o_tx_axis_ready[n]),
            .i_avst_ready      (i_mac_tx_ready[n]),
            .o_avst            (o_mac_tx[n]),
            .o_ptp_tag         (o_mac_ptp_fp[n])
        );

        avst_to_axis_rx #(
            .BYTE_REVERSE      (BYTE_REVERSE)
        ) u_rx (
            .i_avst            (i_mac_rx[n]),
            .o_axis            (rx_axis_int)
        );

        rx_ts_insert u_rx_ts (
            .i_mac_clk         (i_mac_clk),
            .i_mac_rst         (o_mac_rst[n]),
            .i_ptp_rx_its      (i_mac_ptp_rx_its[n]),
            .i_sop             (i_mac_rx[n].startofpacket),
            .i_axis            (rx_axis_int),
            .o_axis            (o_rx_axis[n])
        );

    end

endmodule

// ==== testbench/tb_eth_mac_dual_adapter_props.sv ====
// --------------------
// tb_eth_mac_dual_adapter_props
// concurrent checks on the adapter top level, bound into the DUT
// --------------------

`timescale 1ns/1ps

module tb_eth_mac_dual_adapter_props
    import eth_mac_pkg::*;
#(
    parameter int N_CH = 2
) (
    input logic                  i_mac_clk,
    input logic     [N_CH-1:0]   i_mac_tx_ready,
    input logic     [N_CH-1:0]   i_tx_axis_ready,
    input logic     [N_CH-1:0]   i_mac_rst,
    input avst_tx_t [N_CH-1:0]   i_mac_tx,
    input axis_rx_t [N_CH-1:0]   i_rx_axis
);

    for (genvar n = 0; n < N_CH; n++) begin : g_ch

        logic accept;
        logic open_q;  // last accepted beat opened a frame without closing it

        assign accept = i_mac_tx[n].valid & i_mac_tx_ready[n];

        always_ff @(posedge i_mac_clk or posedge i_mac_rst[n]) begin
            if (i_mac_rst[n]) begin
                open_q <= 1'b0;
            end else if (accept) begin
                open_q <= i_mac_tx[n].startofpacket & ~i_mac_tx[n].endofpacket;
            end
        end

        a_ready_follows_mac: assert property (@(posedge i_mac_clk)
            i_tx_axis_ready[n] == i_mac_tx_ready[n])
            else $error("user TX ready differs from MAC ready on channel %0d", n);

        a_rx_quiet_in_reset: assert property (@(posedge i_mac_clk)
            i_mac_rst[n] |-> !i_rx_axis[n].valid)
            else $error("RX valid high during channel reset on channel %0d", n);

        a_no_double_sop: assert property (@(posedge i_mac_clk) disable iff (i_mac_rst[n])
            (accept && open_q) |-> !i_mac_tx[n].startofpacket)
            else $error("startofpacket inside an open frame on channel %0d", n);

    end

endmodule

bind eth_mac_dual_adapter tb_eth_mac_dual_adapter_props #(
    .N_CH            (N_CH)
) u_props (
    .i_mac_clk       (i_mac_clk),
    .i_mac_tx_ready  (i_mac_tx_ready),
    .i_tx_axis_ready (o_tx_axis_ready),
    .i_mac_rst       (o_mac_rst),
    .i_mac_tx        (o_mac_tx),
    .i_rx_axis       (o_rx_axis)
);

// ==== testbench/tb_eth_mac_dual_adapter.sv ====
// --------------------
// tb_eth_mac_dual_adapter
// directed testbench for the dual-channel MAC adapter, playing the
// MAC on one side and the user logic on the other
// --------------------

`timescale 1ns/1ps

module tb_eth_mac_dual_adapter
    import eth_mac_pkg::*;
();

    localparam int N_CH            = 2;
    localparam int SYNC_STAGES     = 4;
    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 5;
    localparam int STALL_CYCLES    = 4;
    localparam int WATCHDOG_CYCLES = 2000;  // the tests need well under a hundred cycles

    logic                               mac_clk = 1'b0;
    logic                               arst_n;
    axis_tx_t    [N_CH-1:0]             tx_axis;
    logic        [N_CH-1:0]             tx_axis_ready;
    axis_rx_t    [N_CH-1:0]             rx_axis;
    ptp_ts_ret_t [N_CH-1:0]             tx_ptp_ts;
    logic        [N_CH-1:0]             rx_status;
    logic        [N_CH-1:0]             mac_rst;
    avst_tx_t    [N_CH-1:0]             mac_tx;
    logic        [N_CH-1:0]             mac_tx_ready;
    logic        [N_CH-1:0][PTP_TAG_WIDTH-1:0] mac_ptp_fp;
    avst_rx_t    [N_CH-1:0]             mac_rx;
    logic        [N_CH-1:0][PTP_TS_WIDTH-1:0]  mac_ptp_rx_its;
    ptp_ts_ret_t [N_CH-1:0]             mac_ptp_ets;
    logic        [N_CH-1:0]             lanes_stable;
    logic        [N_CH-1:0]             ehip_ready;
    logic        [N_CH-1:0]             pcs_ready;

    integer seed = 93856;
    int     errors = 0;
    int     tests = 0;
    int     failed_tests = 0;

    always #(CLK_PERIOD / 2) mac_clk = ~mac_clk;

    eth_mac_dual_adapter #(
        .N_CH                  (N_CH),
        .SYNC_STAGES           (SYNC_STAGES),
        .BYTE_REVERSE          (1'b1)
    ) UUT (
        .i_mac_clk             (mac_clk),
        .i_arst_n              (arst_n),
        .i_tx_axis             (tx_axis),
        .o_tx_axis_ready       (tx_axis_ready),
        .o_rx_axis             (rx_axis),
        .o_tx_ptp_ts           (tx_ptp_ts),
        .o_rx_status           (rx_status),
        .o_mac_rst             (mac_rst),
        .o_mac_tx              (mac_tx),
        .i_mac_tx_ready        (mac_tx_ready),
        .o_mac_ptp_fp          (mac_ptp_fp),
        .i_mac_rx              (mac_rx),
        .i_mac_ptp_rx_its      (mac_ptp_rx_its),
        .i_mac_ptp_ets         (mac_ptp_ets),
        .i_mac_tx_lanes_stable (lanes_stable),
        .i_mac_ehip_ready      (ehip_ready),
        .i_mac_rx_pcs_ready    (pcs_ready)
    );

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge mac_clk);
        #1;
    endtask

    task automatic mismatch(input string sig, input logic [127:0] got, input logic [127:0] exp);
        errors++;
        $display("error at %0t: %s is 0x%0h, expected 0x%0h", $time, sig, got, exp);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // byte i of the AXI word sits in lane KEEP_WIDTH-1-i on Avalon
    function automatic logic [DATA_WIDTH-1:0] reverse_bytes(input logic [DATA_WIDTH-1:0] d);
        logic [DATA_WIDTH-1:0] r;
        for (int i = 0; i < KEEP_WIDTH; i++) begin
            r[DATA_WIDTH-8-8*i +: 8] = d[8*i +: 8];
        end
        return r;
    endfunction

    function automatic logic [EMPTY_WIDTH-1:0] zero_keep_count(input logic [KEEP_WIDTH-1:0] keep);
        int n;
        n = 0;
        for (int i = 0; i < KEEP_WIDTH; i++) begin
            if (!keep[i]) begin
                n++;
            end
        end
        return EMPTY_WIDTH'(n);
    endfunction

    function automatic logic [KEEP_WIDTH-1:0] expected_rx_keep(input avst_rx_t beat);
        logic [KEEP_WIDTH-1:0] k;
        k = '1;
        if (beat.endofpacket) begin
            k = '0;
            for (int i = 0; i < KEEP_WIDTH - int'(beat.empty); i++) begin
                k[i] = 1'b1;
            end
        end
        return k;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] random_data();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [PTP_TS_WIDTH-1:0] random_ts();
        return {$random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic axis_tx_t make_tx_beat(input logic [KEEP_WIDTH-1:0] keep, input logic last,
                                              input logic [PTP_TAG_WIDTH-1:0] tag, input logic err);
        axis_tx_t beat;
        beat.valid = 1'b1;
        beat.data  = random_data();
        beat.keep  = keep;
        beat.last  = last;
        beat.user  = {tag, err};
        return beat;
    endfunction

    task automatic check_tx_beat(input int ch, input axis_tx_t beat, input logic exp_sop);
        if (tx_axis_ready[ch] !== mac_tx_ready[ch])
            mismatch("o_tx_axis_ready", 128'(tx_axis_ready[ch]), 128'(mac_tx_ready[ch]));
        if (mac_tx[ch].valid !== beat.valid)
            mismatch("o_mac_tx.valid", 128'(mac_tx[ch].valid), 128'(beat.valid));
        if (mac_tx[ch].data !== reverse_bytes(beat.data))
            mismatch("o_mac_tx.data", 128'(mac_tx[ch].data), 128'(reverse_bytes(beat.data)));
        if (mac_tx[ch].startofpacket !== exp_sop)
            mismatch("o_mac_tx.startofpacket", 128'(mac_tx[ch].startofpacket), 128'(exp_sop));
        if (mac_tx[ch].endofpacket !== beat.last)
            mismatch("o_mac_tx.endofpacket", 128'(mac_tx[ch].endofpacket), 128'(beat.last));
        if (mac_tx[ch].empty !== zero_keep_count(beat.keep))
            mismatch("o_mac_tx.empty", 128'(mac_tx[ch].empty), 128'(zero_keep_count(beat.keep)));
        if (mac_tx[ch].error !== beat.user[0])
            mismatch("o_mac_tx.error", 128'(mac_tx[ch].error), 128'(beat.user[0]));
        if (mac_ptp_fp[ch] !== beat.user[TX_USER_WIDTH-1:1])
            mismatch("o_mac_ptp_fp", 128'(mac_ptp_fp[ch]), 128'(beat.user[TX_USER_WIDTH-1:1]));
    endtask

    // release must land on exactly the SYNC_STAGES-th edge
    task automatic check_release(input logic [N_CH-1:0] chans);
        logic [N_CH-1:0] exp;
        for (int k = 1; k <= SYNC_STAGES; k++) begin
            next_cycle();
            exp = (k < SYNC_STAGES) ? chans : '0;
            if (mac_rst !== exp)
                mismatch("o_mac_rst", 128'(mac_rst), 128'(exp));
        end
    endtask

    task automatic reset_test();
        int e0;
        e0 = errors;
        mac_rx[0] = '{valid: 1'b1, startofpacket: 1'b1, endofpacket: 1'b1, default: '0};
        repeat (RESET_CYCLES) next_cycle();
        if (mac_rst !== '1)
            mismatch("o_mac_rst", 128'(mac_rst), 128'({N_CH{1'b1}}));
        if (rx_axis[0].valid !== 1'b0)
            mismatch("o_rx_axis.valid", 128'(rx_axis[0].valid), 128'(1'b0));
        mac_rx[0] = '0;
        arst_n = 1'b1;
        check_release('1);
        lanes_stable[1] = 1'b0;
        mac_rx[1] = '{valid: 1'b1, startofpacket: 1'b1, endofpacket: 1'b1, default: '0};
        #1;
        if (mac_rst !== 2'b10)
            mismatch("o_mac_rst", 128'(mac_rst), 128'(2'b10));
        next_cycle();
        if (rx_axis[1].valid !== 1'b0)
            mismatch("o_rx_axis.valid", 128'(rx_axis[1].valid), 128'(1'b0));
        mac_rx[1] = '0;
        lanes_stable[1] = 1'b1;
        check_release(2'b10);
        ehip_ready[0] = 1'b0;
        mac_rx[0] = '{valid: 1'b1, startofpacket: 1'b1, endofpacket: 1'b1, default: '0};
        #1;
        if (mac_rst !== 2'b01)
            mismatch("o_mac_rst", 128'(mac_rst), 128'(2'b01));
        next_cycle();
        if (rx_axis[0].valid !== 1'b0)
            mismatch("o_rx_axis.valid", 128'(rx_axis[0].valid), 128'(1'b0));
        mac_rx[0] = '0;
        ehip_ready[0] = 1'b1;
        check_release(2'b01);
        finish_test("reset", e0);
    endtask

    task automatic tx_frame_test(input int ch, input logic [KEEP_WIDTH-1:0] last_keep);
        axis_tx_t                 beat;
        logic [PTP_TAG_WIDTH-1:0] tag;
        int                       e0;
        e0 = errors;
        tag = PTP_TAG_WIDTH'($random(seed));
        mac_tx_ready[ch] = 1'b1;
        for (int b = 0; b < 3; b++) begin
            beat = make_tx_beat((b == 2) ? last_keep : '1, b == 2, tag, b == 1);
            tx_axis[ch] = beat;
            #1;
            check_tx_beat(ch, beat, b == 0);
            next_cycle();
        end
        tx_axis[ch] = '0;
        finish_test($sformatf("tx framing ch%0d", ch), e0);
    endtask

    task automatic backpressure_test();
        axis_tx_t                 beat;
        logic [PTP_TAG_WIDTH-1:0] tag;
        int                       e0;
        e0 = errors;
        tag = PTP_TAG_WIDTH'($random(seed));
        mac_tx_ready[0] = 1'b1;
        beat = make_tx_beat('1, 1'b0, tag, 1'b0);
        tx_axis[0] = beat;
        #1;
        check_tx_beat(0, beat, 1'b1);
        next_cycle();
        beat = make_tx_beat('1, 1'b0, tag, 1'b1);
        tx_axis[0] = beat;
        #1;
        check_tx_beat(0, beat, 1'b0);
        next_cycle();
        // the closing beat is held, so an early accept would reopen the frame
        beat = make_tx_beat(8'h3f, 1'b1, tag, 1'b0);
        tx_axis[0] = beat;
        mac_tx_ready[0] = 1'b0;
        repeat (STALL_CYCLES) begin
            #1;
            check_tx_beat(0, beat, 1'b0);  // held beat, frame stays open
            next_cycle();
        end
        mac_tx_ready[0] = 1'b1;
        #1;
        check_tx_beat(0, beat, 1'b0);
        next_cycle();
        tx_axis[0] = '0;
        #1;
        if (mac_tx[0].startofpacket !== 1'b1)
            mismatch("o_mac_tx.startofpacket", 128'(mac_tx[0].startofpacket), 128'(1'b1));
        next_cycle();
        finish_test("tx backpressure", e0);
    endtask

    task automatic rx_frame_test(input int ch);
        avst_rx_t                beat;
        logic [PTP_TS_WIDTH-1:0] sop_ts;
        int                      e0;
        e0 = errors;
        for (int b = 0; b < 3; b++) begin
            beat.valid         = 1'b1;
            beat.data          = random_data();
            beat.startofpacket = (b == 0);
            beat.endofpacket   = (b == 2);
            beat.empty         = (b == 2) ? 3'd5 : 3'd0;
            beat.error         = (b == 1) ? 6'b001000 : 6'b000000;
            mac_rx[ch] = beat;
            mac_ptp_rx_its[ch] = random_ts();  // moves on every beat of the frame
            if (b == 0) begin
                sop_ts = mac_ptp_rx_its[ch];
            end
            next_cycle();
            if (rx_axis[ch].valid !== 1'b1)
                mismatch("o_rx_axis.valid", 128'(rx_axis[ch].valid), 128'(1'b1));
            if (rx_axis[ch].data !== reverse_bytes(beat.data))
                mismatch("o_rx_axis.data", 128'(rx_axis[ch].data), 128'(reverse_bytes(beat.data)));
            if (rx_axis[ch].keep !== expected_rx_keep(beat))
                mismatch("o_rx_axis.keep", 128'(rx_axis[ch].keep), 128'(expected_rx_keep(beat)));
            if (rx_axis[ch].last !== beat.endofpacket)
                mismatch("o_rx_axis.last", 128'(rx_axis[ch].last), 128'(beat.endofpacket));
            if (rx_axis[ch].user[0] !== (beat.error != '0))
                mismatch("o_rx_axis.user[0]", 128'(rx_axis[ch].user[0]), 128'(beat.error != '0));
            if (rx_axis[ch].user[RX_USER_WIDTH-1:1] !== sop_ts)
                mismatch("o_rx_axis.user ts", 128'(rx_axis[ch].user[RX_USER_WIDTH-1:1]),
                         128'(sop_ts));
        end
        mac_rx[ch] = '0;
        next_cycle();
        if (rx_axis[ch].valid !== 1'b0)
            mismatch("o_rx_axis.valid", 128'(rx_axis[ch].valid), 128'(1'b0));
        finish_test($sformatf("rx frame ch%0d", ch), e0);
    endtask

    task automatic passthrough_test();
        ptp_ts_ret_t ets;
        int          e0;
        e0 = errors;
        for (int ch = 0; ch < N_CH; ch++) begin
            ets.valid = 1'b1;
            ets.ts    = random_ts();
            ets.tag   = PTP_TAG_WIDTH'($random(seed));
            mac_ptp_ets[ch] = ets;
            pcs_ready[ch]   = 1'b1;
            #1;
            if (tx_ptp_ts[ch] !== ets)
                mismatch("o_tx_ptp_ts", 128'(tx_ptp_ts[ch]), 128'(ets));
            if (rx_status !== pcs_ready)
                mismatch("o_rx_status", 128'(rx_status), 128'(pcs_ready));
            next_cycle();
        end
        // a single-beat frame each way on channel 0 only
        tx_axis[0] = make_tx_beat('1, 1'b1, 8'h5a, 1'b0);
        mac_rx[0]  = '{valid: 1'b1, startofpacket: 1'b1, endofpacket: 1'b1, default: '0};
        #1;
        if (mac_tx[1].valid !== 1'b0)
            mismatch("o_mac_tx.valid", 128'(mac_tx[1].valid), 128'(1'b0));
        next_cycle();
        tx_axis[0] = '0;
        mac_rx[0]  = '0;
        if (rx_axis[0].valid !== 1'b1)
            mismatch("o_rx_axis.valid", 128'(rx_axis[0].valid), 128'(1'b1));
        if (rx_axis[1].valid !== 1'b0)
            mismatch("o_rx_axis.valid", 128'(rx_axis[1].valid), 128'(1'b0));
        next_cycle();
        finish_test("passthrough", e0);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge mac_clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        arst_n         = 1'b0;
        tx_axis        = '0;
        mac_tx_ready   = '0;
        mac_rx         = '0;
        mac_ptp_rx_its = '0;
        mac_ptp_ets    = '0;
        lanes_stable   = '1;
        ehip_ready     = '1;
        pcs_ready      = '0;
        reset_test();
        tx_frame_test(0, 8'h1f);
        tx_frame_test(1, 8'h01);
        backpressure_test();
        rx_frame_test(0);
        rx_frame_test(1);
        passthrough_test();
        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== eth_mac_dual_adapter.f ====
src/eth_mac_pkg.sv
src/mac_reset_sync.sv
src/axis_to_avst_tx.sv
src/avst_to_axis_rx.sv
src/rx_ts_insert.sv
src/eth_mac_dual_adapter.sv
testbench/tb_eth_mac_dual_adapter_props.sv
testbench/tb_eth_mac_dual_adapter.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the dual-channel MAC adapter testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_eth_mac_dual_adapter \
    -f eth_mac_dual_adapter.f

./obj_dir/Vtb_eth_mac_dual_adapter | tee sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished, see sim.log"
